// File: common/ctrl_pkg.sv
/* bus types, register map and settings addresses shared by the control core
   modules pull these in with a wildcard import in their headers */
`default_nettype none

package ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths with a meaning
   typedef logic [10:0] wb_adr_t;    // byte address, bit 1 picks the halfword
   typedef logic [15:0] wb_dat_t;
   typedef logic [1:0]  wb_sel_t;
   typedef logic [3:0]  region_t;    // address bits 10..7
   typedef logic [6:0]  reg_ofs_t;   // offset inside a region
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   ////////////////////////////////////////////////////////////////////////////
   // grouped signals
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    we;
      logic    cyc;
      logic    stb;
   } wb_req_t;                       // master to slave

   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
   } wb_rsp_t;                       // slave to master

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   typedef struct packed {
      wb_dat_t    leds;
      logic       cgen_sync_b;
      logic       cgen_ref_sel;
      wb_dat_t    tx_frame_len;
      logic       tx_enable;
      logic       rx_enable;
      logic [7:0] rate;
   } board_ctrl_t;

   ////////////////////////////////////////////////////////////////////////////
   // address map
   localparam region_t REGION_BOARD    = 4'd0;
   localparam region_t REGION_SETTINGS = 4'd5;

   localparam reg_ofs_t REG_LEDS        = 7'd0;   // rw
   localparam reg_ofs_t REG_SWITCHES    = 7'd2;   // ro
   localparam reg_ofs_t REG_CGEN_CTRL   = 7'd4;   // rw
   localparam reg_ofs_t REG_CGEN_ST     = 7'd6;   // ro
   localparam reg_ofs_t REG_TEST        = 7'd8;   // rw
   localparam reg_ofs_t REG_RX_FRAMELEN = 7'd10;  // ro
   localparam reg_ofs_t REG_TX_FRAMELEN = 7'd12;  // rw
   localparam reg_ofs_t REG_XFER_RATE   = 7'd14;  // rw
   localparam reg_ofs_t REG_COMPAT      = 7'd16;  // ro

   localparam set_addr_t SR_CLEAR_FIFO = 8'd6;    // 1 reg
   localparam set_addr_t SR_TIME64     = 8'd28;   // 3 regs

   localparam logic [7:0] WHOAMI     = 8'd0;
   localparam logic [7:0] COMPAT_NUM = 8'd2;
   localparam wb_dat_t    BAD_READ   = 16'hBEEF;

endpackage

`default_nettype wire

// File: hw/wb_decode.sv
/* single-master wishbone decoder, steers the request by region and
   returns the addressed slave's read data and ack */
`default_nettype none

module wb_decode
   import ctrl_pkg::*;
(
   input  wire wb_req_t wb_req_i,     // from the master
   output wb_rsp_t      wb_rsp_o,

   output wb_req_t      board_req_o,  // region 0
   input  wire wb_rsp_t board_rsp_i,

   output wb_req_t      set_req_o,    // region 5
   input  wire wb_rsp_t set_rsp_i
);

   region_t region;
   logic    hit_board;
   logic    hit_set;

   assign region    = wb_req_i.adr[10:7];
   assign hit_board = (region == REGION_BOARD);
   assign hit_set   = (region == REGION_SETTINGS);

   ////////////////////////////////////////////////////////////////////////////
   // request fan-out

   // everything but stb goes to every slave unchanged
   always_comb
   begin
      board_req_o     = wb_req_i;
      board_req_o.stb = wb_req_i.stb & hit_board;
   end

   always_comb
   begin
      set_req_o     = wb_req_i;
      set_req_o.stb = wb_req_i.stb & hit_set;
   end

   ////////////////////////////////////////////////////////////////////////////
   // response mux

   always_comb
   begin
      if (hit_board)
      begin
         wb_rsp_o = board_rsp_i;
      end
      else if (hit_set)
      begin
         wb_rsp_o = set_rsp_i;
      end
      else
      begin
         // nothing lives here, the master's cycle never completes
         wb_rsp_o = '0;
      end
   end

endmodule

`default_nettype wire

// File: hw/board_regs.sv
/* board control and status registers on wishbone region 0, plus the
   settings register that issues the tx/rx fifo clear pulses */
`default_nettype none

module board_regs
   import ctrl_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst,

   input  wire wb_req_t req_i,
   output wb_rsp_t      rsp_o,
   input  wire set_bus_t set_i,

   input  wire [2:0]    cgen_st_i,       // status, ld, refmon
   input  wire wb_dat_t rx_frame_len_i,

   output board_ctrl_t  ctrl_o,
   output logic         clear_tx_o,
   output logic         clear_rx_o
);

   reg_ofs_t ofs;
   logic     wr_en;

   wb_dat_t  reg_leds;
   wb_dat_t  reg_cgen_ctrl;
   wb_dat_t  reg_test;
   wb_dat_t  reg_tx_frame_len;
   wb_dat_t  reg_xfer_rate;

   assign ofs   = req_i.adr[6:0];
   assign wr_en = req_i.cyc & req_i.stb & req_i.we;

   ////////////////////////////////////////////////////////////////////////////
   // writable registers

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds         <= '0;
         reg_cgen_ctrl    <= 16'd3;   // sync_b high, ref_sel high
         reg_test         <= '0;
         reg_tx_frame_len <= '0;
         reg_xfer_rate    <= '0;
      end
      else if (wr_en)
      begin
         case (ofs)
            REG_LEDS        : reg_leds         <= req_i.dat;
            REG_CGEN_CTRL   : reg_cgen_ctrl    <= req_i.dat;
            REG_TEST        : reg_test         <= req_i.dat;
            REG_TX_FRAMELEN : reg_tx_frame_len <= req_i.dat;
            REG_XFER_RATE   : reg_xfer_rate    <= req_i.dat;
            default         : ;               // read-only or unmapped
         endcase
      end
   end

   assign ctrl_o.leds         = reg_leds;
   assign ctrl_o.cgen_sync_b  = reg_cgen_ctrl[1];
   assign ctrl_o.cgen_ref_sel = reg_cgen_ctrl[0];
   assign ctrl_o.tx_frame_len = reg_tx_frame_len;
   assign ctrl_o.tx_enable    = reg_xfer_rate[15];
   assign ctrl_o.rx_enable    = reg_xfer_rate[14];
   assign ctrl_o.rate         = reg_xfer_rate[7:0];

   ////////////////////////////////////////////////////////////////////////////
   // read side

   always_comb
   begin
      case (ofs)
         REG_LEDS        : rsp_o.dat = reg_leds;
         REG_SWITCHES    : rsp_o.dat = '0;     // no switches on this board
         REG_CGEN_CTRL   : rsp_o.dat = reg_cgen_ctrl;
         REG_CGEN_ST     : rsp_o.dat = {13'd0, cgen_st_i};
         REG_TEST        : rsp_o.dat = reg_test;
         REG_RX_FRAMELEN : rsp_o.dat = rx_frame_len_i;
         REG_TX_FRAMELEN : rsp_o.dat = reg_tx_frame_len;
         REG_XFER_RATE   : rsp_o.dat = reg_xfer_rate;
         REG_COMPAT      : rsp_o.dat = {WHOAMI, COMPAT_NUM};
         default         : rsp_o.dat = BAD_READ;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;   // zero wait state

   ////////////////////////////////////////////////////////////////////////////
   // fifo clear pulses, bit 1 tx, bit 0 rx

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         clear_tx_o <= 1'b0;
         clear_rx_o <= 1'b0;
      end
      else
      begin
         clear_tx_o <= set_i.stb && (set_i.addr == SR_CLEAR_FIFO) && set_i.data[1];
         clear_rx_o <= set_i.stb && (set_i.addr == SR_CLEAR_FIFO) && set_i.data[0];
      end
   end

endmodule

`default_nettype wire

// File: settings/settings_bus16.sv
/* wishbone slave that builds 32-bit settings writes from two halfword writes
   low half first, the high-half write fires the settings strobe */
`default_nettype none

module settings_bus16
   import ctrl_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst,

   input  wire wb_req_t req_i,
   output wb_rsp_t      rsp_o,

   output set_bus_t     set_o
);

   logic    wr_en;
   logic    wr_hi;        // second halfword of a setting
   wb_dat_t low_half;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;
   assign wr_hi = wr_en & req_i.adr[1];

   ////////////////////////////////////////////////////////////////////////////
   // halfword assembly

   always_ff @(posedge wb_clk)
   begin
      if (wr_en && !req_i.adr[1])
      begin
         low_half <= req_i.dat;
      end
   end

   // settings register number sits on word address bits 6..2
   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
      begin
         set_o.addr <= set_addr_t'(req_i.adr[6:2]);
         set_o.data <= {req_i.dat, low_half};
      end
   end

   // strobe follows the ack of the high write by one cycle
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         set_o.stb <= 1'b0;
      end
      else
      begin
         set_o.stb <= wr_hi;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // bus response

   assign rsp_o.dat = '0;                      // write-only space
   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

`default_nettype wire

// File: settings/vita_time64.sv
/* 64-bit vita time, seconds plus ticks, loaded from the settings bus either
   at once or on the next pps edge; BASE picks its three settings addresses */
`default_nettype none

module vita_time64
   import ctrl_pkg::*;
#(
   parameter set_addr_t   BASE          = SR_TIME64,
   parameter int unsigned TICKS_PER_SEC = 64_000_000
)
(
   input  wire           wb_clk,
   input  wire           wb_rst,

   input  wire set_bus_t set_i,

   input  wire           pps_i,        // async board pps
   output logic          pps_int_o,
   output vita_time_t    vita_time_o
);

   localparam set_addr_t   ADDR_SECS  = BASE;
   localparam set_addr_t   ADDR_TICKS = BASE + 8'd1;
   localparam set_addr_t   ADDR_CTRL  = BASE + 8'd2;
   localparam logic [31:0] TICK_MAX   = 32'(TICKS_PER_SEC - 1);

   vita_time_t pending;
   logic       ctrl_wr;
   logic       load_now;
   logic       arm_pps;
   logic       armed;
   logic       pps_meta;
   logic       pps_sync;
   logic       pps_dly;

   assign ctrl_wr  = set_i.stb && (set_i.addr == ADDR_CTRL);
   assign load_now = ctrl_wr & set_i.data[0];
   assign arm_pps  = ctrl_wr & ~set_i.data[0];

   ////////////////////////////////////////////////////////////////////////////
   // pending value from settings

   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && (set_i.addr == ADDR_SECS))
         pending.secs <= set_i.data;
      if (set_i.stb && (set_i.addr == ADDR_TICKS))
         pending.ticks <= set_i.data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // pps sync and rising edge

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta  <= 1'b0;
         pps_sync  <= 1'b0;
         pps_dly   <= 1'b0;
         pps_int_o <= 1'b0;
      end
      else
      begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_dly   <= pps_sync;
         pps_int_o <= pps_sync & ~pps_dly;
      end
   end

   // armed until the next pps, an immediate load cancels it
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         armed <= 1'b0;
      else if (load_now)
         armed <= 1'b0;
      else if (arm_pps)
         armed <= 1'b1;
      else if (pps_int_o)
         armed <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // counter, loads win over counting

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o <= '0;
      end
      else if (load_now || (pps_int_o && armed))
      begin
         vita_time_o <= pending;
      end
      else if (vita_time_o.ticks == TICK_MAX)
      begin
         vita_time_o.ticks <= '0;
         vita_time_o.secs  <= vita_time_o.secs + 32'd1;
      end
      else
      begin
         vita_time_o.ticks <= vita_time_o.ticks + 32'd1;
      end
   end

endmodule

`default_nettype wire

// File: hw/sdr_ctrl_core.sv
/* control plane top, a 16-bit wishbone slave holding the board registers,
   the settings bus bridge and the vita time counter */
`default_nettype none

module sdr_ctrl_core
   import ctrl_pkg::*;
#(
   parameter int unsigned TICKS_PER_SEC = 64_000_000
)
(
   input  wire           wb_clk,
   input  wire           wb_rst,

   input  wire wb_req_t  wb_req_i,
   output wb_rsp_t       wb_rsp_o,

   input  wire [2:0]     cgen_st_i,
   input  wire wb_dat_t  rx_frame_len_i,
   output board_ctrl_t   ctrl_o,

   output logic          clear_tx_o,
   output logic          clear_rx_o,

   input  wire           pps_i,
   output logic          pps_int_o,
   output vita_time_t    vita_time_o
);

   wb_req_t  board_req;
   wb_rsp_t  board_rsp;
   wb_req_t  set_req;
   wb_rsp_t  set_rsp;
   set_bus_t set_bus;

   ////////////////////////////////////////////////////////////////////////////
   // intercon

   wb_decode u_decode (
      .wb_req_i   (wb_req_i),    .wb_rsp_o    (wb_rsp_o),
      .board_req_o(board_req),   .board_rsp_i (board_rsp),
      .set_req_o  (set_req),     .set_rsp_i   (set_rsp)
   );

   ////////////////////////////////////////////////////////////////////////////
   // slaves

   board_regs u_board (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(board_req), .rsp_o(board_rsp), .set_i(set_bus),
      .cgen_st_i(cgen_st_i), .rx_frame_len_i(rx_frame_len_i),
      .ctrl_o(ctrl_o), .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o)
   );

   settings_bus16 u_settings (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus)
   );

   vita_time64 #(.BASE(SR_TIME64), .TICKS_PER_SEC(TICKS_PER_SEC)) u_time (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .pps_i(pps_i), .pps_int_o(pps_int_o), .vita_time_o(vita_time_o)
   );

endmodule

`default_nettype wire

// File: sim/sdr_ctrl_assertions.sv
/* concurrent checks on the control core ports, bound into sdr_ctrl_core;
   fail_total sums the failures of every property */
`default_nettype none

module sdr_ctrl_assertions
   import ctrl_pkg::*;
(
   input wire             wb_clk,
   input wire             wb_rst,
   input wire wb_req_t    wb_req_i,
   input wire wb_rsp_t    wb_rsp_o,
   input wire             clear_tx_o,
   input wire             clear_rx_o,
   input wire             pps_i,
   input wire             pps_int_o,
   input wire vita_time_t vita_time_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic        mapped;
   int unsigned ack_fails   = 0;
   int unsigned tx_fails    = 0;
   int unsigned rx_fails    = 0;
   int unsigned pps_fails   = 0;
   int unsigned reset_fails = 0;
   int unsigned fail_total;

   assign mapped = (wb_req_i.adr[10:7] == REGION_BOARD) ||
                   (wb_req_i.adr[10:7] == REGION_SETTINGS);
   assign fail_total = ack_fails + tx_fails + rx_fails + pps_fails + reset_fails;

   ////////////////////////////////////////////////////////////////////////////
   // bus and pulses

   // zero wait state on regions 0 and 5, silence elsewhere
   ack_rule: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_rsp_o.ack == (wb_req_i.cyc && wb_req_i.stb && mapped))
   else
   begin
      ack_fails++;
      $error("ack %b with cyc %b stb %b at adr %h", wb_rsp_o.ack, wb_req_i.cyc,
             wb_req_i.stb, wb_req_i.adr);
   end

   tx_clear_width: assert property (@(posedge wb_clk) disable iff (wb_rst)
      clear_tx_o |=> !clear_tx_o)
   else
   begin
      tx_fails++;
      $error("clear_tx_o held longer than one cycle");
   end

   rx_clear_width: assert property (@(posedge wb_clk) disable iff (wb_rst)
      clear_rx_o |=> !clear_rx_o)
   else
   begin
      rx_fails++;
      $error("clear_rx_o held longer than one cycle");
   end

   // two sync flops plus the edge register
   pps_latency: assert property (@(posedge wb_clk) disable iff (wb_rst)
      pps_int_o == ($past(pps_i, 3) && !$past(pps_i, 4)))
   else
   begin
      pps_fails++;
      $error("pps_int_o %b does not follow the pps_i rise by 3 cycles", pps_int_o);
   end

   reset_state: assert property (@(posedge wb_clk)
      wb_rst |=> (!clear_tx_o && !clear_rx_o && !pps_int_o && vita_time_o == '0))
   else
   begin
      reset_fails++;
      $error("outputs not cleared by reset");
   end

endmodule

`default_nettype wire

// File: sim/tb_sdr_ctrl_core.sv
/* testbench for the control core, walks the register map, the settings bridge,
   the fifo clears and both vita time loads against a reference time model */
`default_nettype none

module tb_sdr_ctrl_core
   import ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned TICKS   = 20;
   localparam int          NO_LOAD = -1;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic [2:0]  cgen_st;
   wb_dat_t     rx_frame_len;
   board_ctrl_t ctrl;
   logic        clear_tx;
   logic        clear_rx;
   logic        pps;
   logic        pps_int;
   vita_time_t  vita_time;

   integer      seed;
   int          errors      = 0;
   int          time_errors = 0;
   int          cycle       = 0;
   int          load_at     = NO_LOAD;   // cycle in which the model takes load_val
   int          tx_pulses   = 0;
   int          rx_pulses   = 0;
   vita_time_t  load_val;
   vita_time_t  exp_time;

   sdr_ctrl_core #(.TICKS_PER_SEC(TICKS)) u_dut (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st), .rx_frame_len_i(rx_frame_len), .ctrl_o(ctrl),
      .clear_tx_o(clear_tx), .clear_rx_o(clear_rx),
      .pps_i(pps), .pps_int_o(pps_int), .vita_time_o(vita_time)
   );

   bind sdr_ctrl_core sdr_ctrl_assertions u_assert (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
      .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o), .pps_i(pps_i),
      .pps_int_o(pps_int_o), .vita_time_o(vita_time_o)
   );

   always #50 wb_clk = ~wb_clk;

   ////////////////////////////////////////////////////////////////////////////
   // reference time and clear pulse counts

   function automatic vita_time_t advance_time(input vita_time_t t);
      vita_time_t n;
      n = t;
      if (t.ticks == 32'(TICKS - 1))
      begin
         n.ticks = '0;
         n.secs  = t.secs + 32'd1;   // wrap carries into seconds
      end
      else
      begin
         n.ticks = t.ticks + 32'd1;
      end
      return n;
   endfunction

   always @(posedge wb_clk)
   begin
      cycle <= cycle + 1;
      if (wb_rst)
         exp_time <= '0;
      else if (cycle == load_at)
         exp_time <= load_val;
      else
         exp_time <= advance_time(exp_time);
      if (clear_tx === 1'b1)
         tx_pulses <= tx_pulses + 1;
      if (clear_rx === 1'b1)
         rx_pulses <= rx_pulses + 1;
   end

   always @(negedge wb_clk)
   begin
      if (!wb_rst && vita_time !== exp_time)
      begin
         time_errors <= time_errors + 1;
         $display("ERR %0t vita_time_o expected %h actual %h", $time, exp_time, vita_time);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // bus helpers, all start and end on a falling edge

   function automatic wb_adr_t board_adr(input reg_ofs_t ofs);
      return {REGION_BOARD, ofs};
   endfunction

   task automatic compare_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic bus_cycle(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                            output wb_dat_t rdat, output logic acked);
      int waited;
      waited     = 0;
      acked      = 1'b0;
      rdat       = '0;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      wb_req.sel = 2'b11;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      while (!acked && waited < 16)
      begin
         @(posedge wb_clk);
         if (wb_rsp.ack)
         begin
            acked = 1'b1;
            rdat  = wb_rsp.dat;
         end
         waited++;
      end
      @(negedge wb_clk);
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic write_word(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t rdat;
      logic    acked;
      bus_cycle(adr, 1'b1, dat, rdat, acked);
      if (!acked)
      begin
         errors++;
         $display("timeout: write to address %h was never acknowledged", adr);
      end
   endtask

   task automatic read_expect(input wb_adr_t adr, input wb_dat_t exp, input string name);
      wb_dat_t rdat;
      logic    acked;
      bus_cycle(adr, 1'b0, '0, rdat, acked);
      if (!acked)
      begin
         errors++;
         $display("timeout: read of %s was never acknowledged", name);
      end
      else
         compare_value(name, 64'(exp), 64'(rdat));
   endtask

   // low half first, the high half fires the strobe
   task automatic send_setting(input set_addr_t num, input set_data_t val);
      wb_adr_t base;
      base = {REGION_SETTINGS, num[4:0], 2'b00};
      write_word(base, val[15:0]);
      write_word(base | 11'd2, val[31:16]);
   endtask

   task automatic wait_clear(input int tx_base);
      int n;
      n = 0;
      while (tx_pulses == tx_base && n < 8)
      begin
         @(negedge wb_clk);
         n++;
      end
      if (tx_pulses == tx_base)
      begin
         errors++;
         $display("timeout: no tx fifo clear pulse after the settings write");
      end
      repeat (4) @(negedge wb_clk);   // room for a stray second pulse
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial
   begin
      board_ctrl_t exp_ctrl;
      wb_dat_t     rdat;
      logic        acked;
      int          tx_base;
      int          rx_base;
      int          pick;
      int          n;

      seed         = 32'h8cb1_ef1b;
      wb_rst       = 1'b1;
      wb_req       = '0;
      cgen_st      = 3'd0;
      rx_frame_len = '0;
      pps          = 1'b0;
      load_val     = '0;
      repeat (10) @(negedge wb_clk);
      wb_rst = 1'b0;

      // reset values, then every writable register
      exp_ctrl              = '0;
      exp_ctrl.cgen_sync_b  = 1'b1;
      exp_ctrl.cgen_ref_sel = 1'b1;
      compare_value("ctrl_o", 64'(exp_ctrl), 64'(ctrl));
      write_word(board_adr(REG_LEDS), 16'hA5C3);
      write_word(board_adr(REG_CGEN_CTRL), 16'h0002);
      write_word(board_adr(REG_TEST), 16'h1234);
      write_word(board_adr(REG_TX_FRAMELEN), 16'd1500);
      write_word(board_adr(REG_XFER_RATE), 16'h8042);
      read_expect(board_adr(REG_LEDS), 16'hA5C3, "leds");
      read_expect(board_adr(REG_CGEN_CTRL), 16'h0002, "cgen_ctrl");
      read_expect(board_adr(REG_TEST), 16'h1234, "test");
      read_expect(board_adr(REG_TX_FRAMELEN), 16'd1500, "tx_frame_len");
      read_expect(board_adr(REG_XFER_RATE), 16'h8042, "xfer_rate");
      exp_ctrl = {16'hA5C3, 1'b1, 1'b0, 16'd1500, 1'b1, 1'b0, 8'h42};
      compare_value("ctrl_o", 64'(exp_ctrl), 64'(ctrl));
      write_word(board_adr(REG_XFER_RATE), 16'h40FF);
      exp_ctrl = {16'hA5C3, 1'b1, 1'b0, 16'd1500, 1'b0, 1'b1, 8'hFF};
      compare_value("ctrl_o", 64'(exp_ctrl), 64'(ctrl));

      // read-only words and unused offsets
      cgen_st      = 3'b101;
      rx_frame_len = 16'h0BAD;
      read_expect(board_adr(REG_COMPAT), 16'h0002, "compat");
      read_expect(board_adr(REG_CGEN_ST), 16'h0005, "cgen_st");
      read_expect(board_adr(REG_RX_FRAMELEN), 16'h0BAD, "rx_frame_len");
      for (n = 0; n < 4; n++)
      begin
         pick = $random(seed);
         read_expect(board_adr(reg_ofs_t'(18 + (pick & 32'h7fff) % 110)), 16'hBEEF,
                     "unused offset");
      end

      // region 3 holds nothing
      bus_cycle({4'd3, 7'd0}, 1'b0, '0, rdat, acked);
      if (acked)
      begin
         errors++;
         $display("region 3 acknowledged an access although nothing is mapped there");
      end

      // fifo clears, tx only then both
      tx_base = tx_pulses;
      rx_base = rx_pulses;
      send_setting(SR_CLEAR_FIFO, 32'd2);
      wait_clear(tx_base);
      compare_value("clear_tx_o pulses", 64'd1, 64'(tx_pulses - tx_base));
      compare_value("clear_rx_o pulses", 64'd0, 64'(rx_pulses - rx_base));
      tx_base = tx_pulses;
      rx_base = rx_pulses;
      send_setting(SR_CLEAR_FIFO, 32'd3);
      wait_clear(tx_base);
      compare_value("clear_tx_o pulses", 64'd1, 64'(tx_pulses - tx_base));
      compare_value("clear_rx_o pulses", 64'd1, 64'(rx_pulses - rx_base));

      // immediate load of 5 s and 18 ticks
      send_setting(SR_TIME64, 32'd5);
      send_setting(SR_TIME64 + 8'd1, 32'd18);
      send_setting(SR_TIME64 + 8'd2, 32'd1);
      load_val = {32'd5, 32'd18};
      load_at  = cycle;
      @(negedge wb_clk);
      compare_value("vita_time_o", {32'd5, 32'd18}, 64'(vita_time));
      repeat (2) @(negedge wb_clk);
      compare_value("vita_time_o", {32'd6, 32'd0}, 64'(vita_time));
      repeat (30) @(negedge wb_clk);

      // load armed for the next pps edge
      send_setting(SR_TIME64, 32'd100);
      send_setting(SR_TIME64 + 8'd1, 32'd0);
      send_setting(SR_TIME64 + 8'd2, 32'd0);
      repeat (5) @(negedge wb_clk);   // still counting while armed
      load_val = {32'd100, 32'd0};
      load_at  = cycle + 3;
      pps      = 1'b1;
      n        = 0;
      while (!pps_int && n < 8)
      begin
         @(negedge wb_clk);
         n++;
      end
      if (!pps_int)
      begin
         errors++;
         $display("timeout: pps_int_o never pulsed after pps_i rose");
      end
      @(negedge wb_clk);
      compare_value("vita_time_o", {32'd100, 32'd0}, 64'(vita_time));
      repeat (4) @(negedge wb_clk);
      pps = 1'b0;
      repeat (4) @(negedge wb_clk);

      $display("errors: %0d checks, %0d time model, %0d assertions",
               errors, time_errors, u_dut.u_assert.fail_total);
      if (errors + time_errors + u_dut.u_assert.fail_total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
common/ctrl_pkg.sv
hw/wb_decode.sv
hw/board_regs.sv
settings/settings_bus16.sv
settings/vita_time64.sv
hw/sdr_ctrl_core.sv
sim/sdr_ctrl_assertions.sv
sim/tb_sdr_ctrl_core.sv

// File: Makefile
TOP = tb_sdr_ctrl_core
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f list.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
